// File: build.f
+incdir+verif
design/ldstPkg.sv
design/ringBuffCtrl.sv
design/ldstDecode.sv
design/ldstQueue.sv
design/ldstAddrGen.sv
design/ldstResult.sv
design/ldstTop.sv
verif/ldstTb.sv

// File: design/ldstAddrGen.sv
`default_nettype none

module ldstAddrGen
	import ldstPkg::*;
(
	input  wire logic    clock,
	input  wire logic    rstN,
	input  wire logic    headValid,     // Queue not empty
	input  wire ldstCmdT headCmd,
	input  wire logic    memStall,
	output logic         headGrant,     // One-cycle pop
	output logic         memReq,
	output logic         memWrite,
	output addressT      memAddr,
	output dataT         memWrData,
	output logic         tagValid,      // Lines up with read data
	output accessTagT    tag
);

	genStateT state;
	ldstCmdT  cmdReg;                   // Command being walked
	lengthT   idx;                      // Current element index
	logic     take;                     // Access accepted by memory
	logic     lastElem;
	logic     zeroLen;

	//////////////////////////////////////////////////
	// Handshake
	assign headGrant = (state == GenIdle) & headValid;
	assign take      = memReq & ~memStall;
	assign lastElem  = (idx == cmdReg.length - 1'b1);
	assign zeroLen   = (headCmd.length == '0);

	//////////////////////////////////////////////////
	// State and request control
	always_ff @(posedge clock) begin
		if (!rstN) begin
			state    <= GenIdle;
			memReq   <= 1'b0;
			tagValid <= 1'b0;
		end else begin
			tagValid <= take;
			case (state)
				GenIdle: begin
					if (headGrant) begin
						if (zeroLen) begin
							tagValid <= 1'b1; // Marker tag only, stay idle
						end else begin
							state  <= GenRun;
							memReq <= 1'b1;   // Element 0 next cycle
						end
					end
				end
				GenRun: begin
					if (take && lastElem) begin
						state  <= GenIdle;
						memReq <= 1'b0;
					end
				end
				default: state <= GenIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Address walk and payload, no reset
	always_ff @(posedge clock) begin
		if (headGrant) begin
			cmdReg    <= headCmd;
			idx       <= '0;
			memAddr   <= headCmd.base;
			memWrite  <= headCmd.isStore;
			memWrData <= {{(DataWidth - FillWidth){1'b0}}, headCmd.fill}; // Zero-extend
		end else if (take) begin
			idx     <= idx + 1'b1;
			memAddr <= memAddr + cmdReg.stride; // Wraps at 16 bits
		end
	end

	// Tag for each taken access, or the length-0 marker
	always_ff @(posedge clock) begin
		if (headGrant && zeroLen) begin
			tag.isLoad   <= ~headCmd.isStore;
			tag.token    <= headCmd.token;
			tag.index    <= '0;
			tag.last     <= 1'b1;
			tag.noAccess <= 1'b1;
		end else if (take) begin
			tag.isLoad   <= ~cmdReg.isStore;
			tag.token    <= cmdReg.token;
			tag.index    <= idx;
			tag.last     <= lastElem;
			tag.noAccess <= 1'b0;
		end
	end

	// Request held steady while memory stalls
	assert property (@(posedge clock) disable iff (!rstN)
		(memReq && memStall) |=> (memReq && $stable(memAddr) && $stable(memWrite)
			&& $stable(memWrData)));

endmodule

`default_nettype wire

// File: design/ldstDecode.sv
`default_nettype none

module ldstDecode
	import ldstPkg::*;
(
	input  wire logic     clock,
	input  wire logic     rstN,
	input  wire logic     instValid,      // Instruction strobe
	input  wire instWordT instWord,
	input  wire logic     cmdStall,       // Queue full
	output logic          instStall,      // Back-pressure to issuer
	output logic          illegalOp,      // One pulse per reserved opcode
	output logic          cmdValid,
	output ldstCmdT       cmd
);

	instFieldsT fields;
	logic       accept;                   // Word taken this cycle
	logic       isMemOp;                  // Load or store
	ldstCmdT    newCmd;

	//////////////////////////////////////////////////
	// Field split
	assign fields    = instFieldsT'(instWord);
	assign isMemOp   = (fields.opcode == OpLoad) || (fields.opcode == OpStore);
	assign instStall = cmdValid & cmdStall; // Register held while queue is full
	assign accept    = instValid & ~instStall;

	always_comb begin
		newCmd.isStore = (fields.opcode == OpStore);
		newCmd.token   = fields.token;
		newCmd.base    = fields.base;
		newCmd.stride  = fields.stride;
		newCmd.length  = fields.length;
		newCmd.fill    = fields.fill;
	end

	//////////////////////////////////////////////////
	// Output register
	always_ff @(posedge clock) begin
		if (!rstN) begin
			cmdValid  <= 1'b0;
			illegalOp <= 1'b0;
		end else begin
			illegalOp <= accept && (fields.opcode == OpReserved);
			if (!instStall) begin
				cmdValid <= accept & isMemOp; // Nop and reserved leave it empty
			end
		end
	end

	// Payload has no reset
	always_ff @(posedge clock) begin
		if (accept && isMemOp) begin
			cmd <= newCmd;
		end
	end

	// Held command must not change until the queue takes it
	assert property (@(posedge clock) disable iff (!rstN)
		(cmdValid && cmdStall) |=> (cmdValid && $stable(cmd)));

endmodule

`default_nettype wire

// File: design/ldstPkg.sv
`default_nettype none

package ldstPkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	localparam int AddrWidth       = 16;
	localparam int DataWidth       = 32;
	localparam int TokenWidth      = 6;
	localparam int LengthWidth     = 8;
	localparam int FillWidth       = 16;
	localparam int InstWidth       = 64;
	localparam int QueueDepth      = 8;                 // Command queue entries
	localparam int QueuePtrWidth   = 3;
	localparam int QueueCountWidth = QueuePtrWidth + 1; // Holds 0 to QueueDepth

	typedef logic [AddrWidth-1:0]   addressT;           // Word address
	typedef logic [DataWidth-1:0]   dataT;
	typedef logic [TokenWidth-1:0]  tokenT;             // Tag handed back with results
	typedef logic [LengthWidth-1:0] lengthT;            // Element count, zero allowed
	typedef logic [FillWidth-1:0]   fillT;              // Store fill value
	typedef logic [InstWidth-1:0]   instWordT;

	//////////////////////////////////////////////////
	// Enums
	typedef enum logic [1:0] {
		OpNop      = 2'd0,
		OpLoad     = 2'd1,
		OpStore    = 2'd2,
		OpReserved = 2'd3
	} opcodeT;

	typedef enum logic {
		GenIdle = 1'b0,
		GenRun  = 1'b1
	} genStateT;

	//////////////////////////////////////////////////
	// Structs
	// Instruction word layout, MSB first, 64 bits in all
	typedef struct packed {
		opcodeT  opcode;
		tokenT   token;
		addressT base;
		addressT stride;
		lengthT  length;
		fillT    fill;
	} instFieldsT;

	typedef struct packed {
		logic    isStore;
		tokenT   token;
		addressT base;
		addressT stride;
		lengthT  length;
		fillT    fill;
	} ldstCmdT;                                         // 63 bits

	typedef struct packed {
		logic   isLoad;
		tokenT  token;
		lengthT index;                                  // Element number in command
		logic   last;                                   // Final tag of the command
		logic   noAccess;                               // Length-0 marker, no memory access
	} accessTagT;

	typedef struct packed {
		tokenT  token;
		lengthT index;
		dataT   data;
	} ldstResultT;

	typedef struct packed {
		tokenT token;
		logic  isStore;
	} doneT;

endpackage

`default_nettype wire

// File: design/ldstQueue.sv
`default_nettype none

module ldstQueue
	import ldstPkg::*;
(
	input  wire logic    clock,
	input  wire logic    rstN,
	input  wire logic    cmdValid,    // Command offered by decode
	input  wire ldstCmdT cmd,
	input  wire logic    headGrant,   // Pop from address generator
	output logic         cmdStall,    // Full flag back to decode
	output logic         headValid,   // Not empty
	output ldstCmdT      headCmd      // Oldest entry
);

	ldstCmdT                  cmdBuff [QueueDepth];
	logic                     we;
	logic                     re;
	logic [QueuePtrWidth-1:0] wAddr;
	logic [QueuePtrWidth-1:0] rAddr;
	logic                     full;
	logic                     empty;

	//////////////////////////////////////////////////
	// Handshake qualification
	assign we        = cmdValid & ~full;
	assign re        = headGrant & ~empty;

	assign cmdStall  = full;
	assign headValid = ~empty;
	assign headCmd   = cmdBuff[rAddr];  // Visible the cycle after the write

	//////////////////////////////////////////////////
	// Storage
	always_ff @(posedge clock) begin
		if (we) begin
			cmdBuff[wAddr] <= cmd;
		end
	end

	//////////////////////////////////////////////////
	// Pointer control
	ringBuffCtrl uRingBuffCtrl (
		.clock (clock),
		.rstN  (rstN),
		.we    (we),
		.re    (re),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty),
		.count ()
	);

	// A grant only ever follows an offered head
	assert property (@(posedge clock) disable iff (!rstN) headGrant |-> headValid);

endmodule

`default_nettype wire

// File: design/ldstResult.sv
`default_nettype none

module ldstResult
	import ldstPkg::*;
(
	input  wire logic      clock,
	input  wire logic      rstN,
	input  wire logic      tagValid,    // One cycle after a taken access
	input  wire accessTagT tag,
	input  wire dataT      memRdData,   // Valid with the tag of a load
	output logic           resValid,
	output ldstResultT     resData,
	output logic           doneValid,   // Command finished
	output doneT           done
);

	logic loadHit;                      // Tag carries real read data
	logic lastHit;

	//////////////////////////////////////////////////
	// Tag decode
	assign loadHit = tagValid & tag.isLoad & ~tag.noAccess;
	assign lastHit = tagValid & tag.last;

	//////////////////////////////////////////////////
	// Strobes
	always_ff @(posedge clock) begin
		if (!rstN) begin
			resValid  <= 1'b0;
			doneValid <= 1'b0;
		end else begin
			resValid  <= loadHit;       // Stores and markers give no element result
			doneValid <= lastHit;       // Same cycle as last load result
		end
	end

	//////////////////////////////////////////////////
	// Payload, no reset
	always_ff @(posedge clock) begin
		if (loadHit) begin
			resData.token <= tag.token;
			resData.index <= tag.index;
			resData.data  <= memRdData;
		end
	end

	always_ff @(posedge clock) begin
		if (lastHit) begin
			done.token   <= tag.token;
			done.isStore <= ~tag.isLoad;
		end
	end

	// Length-0 marker is always the closing tag of its command
	assert property (@(posedge clock) disable iff (!rstN)
		(tagValid && tag.noAccess) |-> tag.last);

endmodule

`default_nettype wire

// File: design/ldstTop.sv
`default_nettype none

module ldstTop
	import ldstPkg::*;
(
	input  wire logic     clock,
	input  wire logic     rstN,
	// Instruction side
	input  wire logic     instValid,
	input  wire instWordT instWord,
	output logic          instStall,
	output logic          illegalOp,
	// Memory port
	output logic          memReq,
	output logic          memWrite,
	output addressT       memAddr,
	output dataT          memWrData,
	input  wire logic     memStall,
	input  wire dataT     memRdData,   // One-cycle read latency
	// Results
	output logic          resValid,
	output ldstResultT    resData,
	output logic          doneValid,
	output doneT          done
);

	//////////////////////////////////////////////////
	// Internal paths
	logic      cmdValid;
	ldstCmdT   cmd;
	logic      cmdStall;
	logic      headValid;
	ldstCmdT   headCmd;
	logic      headGrant;
	logic      tagValid;
	accessTagT tag;

	ldstDecode uDecode (
		.clock     (clock),
		.rstN      (rstN),
		.instValid (instValid),
		.instWord  (instWord),
		.cmdStall  (cmdStall),
		.instStall (instStall),
		.illegalOp (illegalOp),
		.cmdValid  (cmdValid),
		.cmd       (cmd)
	);

	ldstQueue uQueue (
		.clock     (clock),
		.rstN      (rstN),
		.cmdValid  (cmdValid),
		.cmd       (cmd),
		.headGrant (headGrant),
		.cmdStall  (cmdStall),
		.headValid (headValid),
		.headCmd   (headCmd)
	);

	ldstAddrGen uAddrGen (
		.clock     (clock),
		.rstN      (rstN),
		.headValid (headValid),
		.headCmd   (headCmd),
		.memStall  (memStall),
		.headGrant (headGrant),
		.memReq    (memReq),
		.memWrite  (memWrite),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.tagValid  (tagValid),
		.tag       (tag)
	);

	ldstResult uResult (
		.clock     (clock),
		.rstN      (rstN),
		.tagValid  (tagValid),
		.tag       (tag),
		.memRdData (memRdData),
		.resValid  (resValid),
		.resData   (resData),
		.doneValid (doneValid),
		.done      (done)
	);

endmodule

`default_nettype wire

// File: design/ringBuffCtrl.sv
`default_nettype none

module ringBuffCtrl
	import ldstPkg::*;
(
	input  wire logic                   clock,
	input  wire logic                   rstN,
	input  wire logic                   we,     // Qualified write
	input  wire logic                   re,     // Qualified read
	output logic [QueuePtrWidth-1:0]    wAddr,
	output logic [QueuePtrWidth-1:0]    rAddr,
	output logic                        full,
	output logic                        empty,
	output logic [QueueCountWidth-1:0]  count   // Occupancy
);

	localparam logic [QueuePtrWidth-1:0] LastPtr = QueuePtrWidth'(QueueDepth - 1);

	//////////////////////////////////////////////////
	// Flags from occupancy
	assign full  = (count == QueueCountWidth'(QueueDepth));
	assign empty = (count == '0);

	//////////////////////////////////////////////////
	// Pointers, wrap at the last entry
	always_ff @(posedge clock) begin
		if (!rstN) begin
			wAddr <= '0;
			rAddr <= '0;
		end else begin
			if (we) begin
				wAddr <= (wAddr == LastPtr) ? '0 : wAddr + 1'b1;
			end
			if (re) begin
				rAddr <= (rAddr == LastPtr) ? '0 : rAddr + 1'b1;
			end
		end
	end

	// Count moves only when exactly one side is active
	always_ff @(posedge clock) begin
		if (!rstN) begin
			count <= '0;
		end else begin
			case ({we, re})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Callers must qualify their strobes
	assert property (@(posedge clock) disable iff (!rstN) !(we && full));
	assert property (@(posedge clock) disable iff (!rstN) !(re && empty));

endmodule

`default_nettype wire

// File: verif/ldstRefModel.svh
`ifndef LDST_REF_MODEL_SVH
`define LDST_REF_MODEL_SVH

//////////////////////////////////////////////////
// Expected traffic
typedef struct packed {
	addressT addr;
	logic    write;
	dataT    data;                          // Zero-extended fill for stores
	tokenT   token;
	lengthT  index;
} expAccessT;

expAccessT  expAccessQ [$];                 // Accesses in issue order
ldstResultT expResultQ [$];                 // Load results filled as accesses are taken
doneT       expDoneQ   [$];                 // One per load or store command
dataT       modelMem   [addressT];          // Model copy of memory contents

// Initial memory contents mix every address bit
function automatic dataT memHash(addressT addr);
	return (dataT'(addr) * 32'h9E3779B1) ^ 32'h5A5A0000;
endfunction

function automatic dataT modelRead(addressT addr);
	return modelMem.exists(addr) ? modelMem[addr] : memHash(addr);
endfunction

// Expand an accepted word into its element accesses and done
task automatic predictWord(instWordT word);
	instFieldsT f;
	expAccessT  acc;
	doneT       d;
	f = instFieldsT'(word);
	if (f.opcode == OpLoad || f.opcode == OpStore) begin
		for (int i = 0; i < int'(f.length); i++) begin
			acc.addr  = addressT'(f.base + i * f.stride); // Wraps at 16 bits
			acc.write = (f.opcode == OpStore);
			acc.data  = dataT'(f.fill);
			acc.token = f.token;
			acc.index = lengthT'(i);
			expAccessQ.push_back(acc);
		end
		d.token   = f.token;
		d.isStore = (f.opcode == OpStore);
		expDoneQ.push_back(d);              // Length 0 still closes with a done
	end
endtask

//////////////////////////////////////////////////
// Compare tasks
task automatic compareAccess(expAccessT exp, addressT addr, logic write, dataT wrData);
	if (addr !== exp.addr) begin
		$display("ERROR at %0t: memAddr expected %h got %h", $time, exp.addr, addr);
		stopOnFailure();
	end
	if (write !== exp.write) begin
		$display("ERROR at %0t: memWrite expected %b got %b", $time, exp.write, write);
		stopOnFailure();
	end
	if (exp.write && (wrData !== exp.data)) begin  // Write data only matters on stores
		$display("ERROR at %0t: memWrData expected %h got %h", $time, exp.data, wrData);
		stopOnFailure();
	end
endtask

task automatic compareResult(ldstResultT exp, ldstResultT act);
	string expStr;
	string actStr;
	if (act !== exp) begin
		expStr = $sformatf("token %0d index %0d data %h", exp.token, exp.index, exp.data);
		actStr = $sformatf("token %0d index %0d data %h", act.token, act.index, act.data);
		$display("ERROR at %0t: resData expected %s got %s", $time, expStr, actStr);
		stopOnFailure();
	end
endtask

task automatic compareDone(doneT exp, doneT act);
	if (act !== exp) begin
		$display("ERROR at %0t: done expected token %0d isStore %b got token %0d isStore %b",
			$time, exp.token, exp.isStore, act.token, act.isStore);
		stopOnFailure();
	end
endtask

task automatic compareIllegal(logic exp, logic act);
	if (act !== exp) begin
		$display("ERROR at %0t: illegalOp expected %b got %b", $time, exp, act);
		stopOnFailure();
	end
endtask

`endif

// File: verif/ldstTb.sv
`default_nettype none

module ldstTb
	import ldstPkg::*;
();

	localparam int ClockPeriod  = 8;
	localparam int NumInst      = 300;                        // Accepted words including nops
	localparam int WatchdogTime = NumInst * (8 + 10) * ClockPeriod;

	logic       clock;
	logic       rstN;
	logic       instValid;
	instWordT   instWord;
	logic       instStall;
	logic       illegalOp;
	logic       memReq;
	logic       memWrite;
	addressT    memAddr;
	dataT       memWrData;
	logic       memStall;
	dataT       memRdData;
	logic       resValid;
	ldstResultT resData;
	logic       doneValid;
	doneT       done;

	instFieldsT wordFields;
	dataT       memArray [addressT];                          // Memory behind the DUT port
	logic       illegalExp = 1'b0;                            // Pulse due this cycle
	logic       sawStall   = 1'b0;
	int         numAccepted = 0;
	int         seedDummy;

	assign wordFields = instFieldsT'(instWord);

	task automatic stopOnFailure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "ldstRefModel.svh"

	ldstTop UUT (
		.clock     (clock),
		.rstN      (rstN),
		.instValid (instValid),
		.instWord  (instWord),
		.instStall (instStall),
		.illegalOp (illegalOp),
		.memReq    (memReq),
		.memWrite  (memWrite),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memStall  (memStall),
		.memRdData (memRdData),
		.resValid  (resValid),
		.resData   (resData),
		.doneValid (doneValid),
		.done      (done)
	);

	initial begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// Mostly small bases and strides so stores and loads overlap
	function automatic instWordT randomWord();
		instFieldsT f;
		int         pick;
		pick = $urandom_range(0, 99);
		if (pick < 40) f.opcode = OpLoad;
		else if (pick < 80) f.opcode = OpStore;
		else if (pick < 90) f.opcode = OpNop;
		else f.opcode = OpReserved;
		f.token  = tokenT'($urandom);
		f.base   = addressT'($urandom_range(0, 63));
		if ($urandom_range(0, 7) == 0) f.stride = addressT'($urandom);
		else f.stride = addressT'($urandom_range(0, 5));
		f.length = lengthT'($urandom_range(0, 6));
		f.fill   = fillT'($urandom);
		return instWordT'(f);
	endfunction

	//////////////////////////////////////////////////
	// Memory responder and checks
	task automatic takeAccess();
		expAccessT  exp;
		ldstResultT res;
		if (expAccessQ.size() == 0) begin
			$display("Memory access at time %0t to address %h was not expected", $time, memAddr);
			stopOnFailure();
		end else begin
			exp = expAccessQ.pop_front();
			compareAccess(exp, memAddr, memWrite, memWrData);
			if (exp.write) begin
				modelMem[exp.addr] = exp.data;            // Model updated in access order
			end else begin
				res.token = exp.token;
				res.index = exp.index;
				res.data  = modelRead(exp.addr);
				expResultQ.push_back(res);
			end
		end
		if (memWrite) memArray[memAddr] = memWrData;
		else memRdData <= memArray.exists(memAddr) ? memArray[memAddr] : memHash(memAddr);
	endtask

	always @(posedge clock) begin
		if (rstN) begin
			compareIllegal(illegalExp, illegalOp);
			illegalExp = instValid && !instStall && (wordFields.opcode == OpReserved);
			if (instValid && !instStall) predictWord(instWord);
			if (instStall) sawStall = 1'b1;
			if (memReq && !memStall) takeAccess();
			if (resValid) begin
				if (expResultQ.size() == 0) begin
					$display("Load result at time %0t was not expected", $time);
					stopOnFailure();
				end else compareResult(expResultQ.pop_front(), resData);
			end
			if (doneValid) begin
				if (expDoneQ.size() == 0) begin
					$display("Done pulse at time %0t was not expected", $time);
					stopOnFailure();
				end else compareDone(expDoneQ.pop_front(), done);
			end
		end
	end

	initial begin
		#(WatchdogTime);
		$display("Watchdog expired, the run hung after %0d accepted words", numAccepted);
		stopOnFailure();
	end

	//////////////////////////////////////////////////
	// Stimulus
	initial begin
		seedDummy = $urandom(79137);
		rstN      = 1'b0;
		instValid = 1'b0;
		instWord  = '0;
		memStall  = 1'b0;
		memRdData = '0;
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		while (numAccepted < NumInst) begin
			@(posedge clock);
			memStall <= ($urandom_range(0, 99) < 30);     // Stall about 30% of cycles
			if (instValid && !instStall) numAccepted++;
			if (!(instValid && instStall)) begin          // Word held while stalled
				if (numAccepted < NumInst && $urandom_range(0, 99) < 85) begin
					instValid <= 1'b1;
					instWord  <= randomWord();
				end else begin
					instValid <= 1'b0;
				end
			end
		end
		do begin                                          // Wait for the last done
			@(posedge clock);
			memStall <= ($urandom_range(0, 99) < 30);
		end while (expDoneQ.size() != 0);
		memStall <= 1'b0;
		repeat (10) @(posedge clock);                     // Catch stray outputs
		if (expAccessQ.size() == 0 && expResultQ.size() == 0 && expDoneQ.size() == 0
			&& sawStall) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Expected traffic left over, or instStall never rose");
			stopOnFailure();
		end
	end

endmodule

`default_nettype wire
